//--- common/wb_mix_pkg.sv
// Shared types and sizes for the five-channel Wishbone interconnect
// Imported by the arbiter, the mixer, the memory target and the top level
package wb_mix_pkg;

   // Channel count and index width
   localparam int NUM_CH   = 5;
   localparam int CH_IDX_W = $clog2(NUM_CH);

   // Bus widths
   localparam int DAT_W = 32;
   localparam int ADR_W = 32;
   localparam int SEL_W = DAT_W / 8;   // One select bit per byte lane

   // Memory target geometry, 256 words of 32 bits
   localparam int MEM_WORDS    = 256;
   localparam int ADR_WORD_LSB = 2;    // Byte offset bits below this
   localparam int ADR_WORD_MSB = 9;
   localparam int WORD_IDX_W   = ADR_WORD_MSB - ADR_WORD_LSB + 1;

   // Request from a channel, also used on the master side
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [SEL_W-1:0] sel;
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;
   } wb_req_t;

   // Response from the target
   typedef struct packed {
      logic             ack;
      logic             err;
      logic [DAT_W-1:0] dat;
   } wb_rsp_t;

   // One bit per channel, all zero when nobody owns the bus
   typedef logic [NUM_CH-1:0] grant_t;

   // Arbiter FSM
   typedef enum logic {
      ARB_IDLE,
      ARB_BUSY
   } arb_state_t;

endpackage

//--- hdl/wb_arbiter.sv
// Round-robin arbiter for the shared Wishbone target
// Watches each channel's cyc and produces a registered one-hot grant
// The grant stays with its owner until that channel drops cyc
`timescale 1ns/1ps

module wb_arbiter
   import wb_mix_pkg::*;
(
   input  logic    wb_clk_i,
   input  logic    rst_i,
   input  wb_req_t ch_req_i [NUM_CH],
   output grant_t  grant_o
);

   arb_state_t          state_q;
   grant_t              grant_q;
   logic [CH_IDX_W-1:0] last_q;     // Last served channel
   logic [NUM_CH-1:0]   cyc_vec;
   logic [CH_IDX_W-1:0] pick;
   logic                pick_vld;

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         cyc_vec[i] = ch_req_i[i].cyc;
      end
   end

   // Scan downwards so the channel closest after last_q wins,
   // last_q itself comes around with the lowest priority
   always_comb begin
      pick     = last_q;
      pick_vld = 1'b0;
      for (int i = NUM_CH; i >= 1; i--) begin
         if (cyc_vec[(int'(last_q) + i) % NUM_CH]) begin
            pick     = CH_IDX_W'((int'(last_q) + i) % NUM_CH);
            pick_vld = 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         state_q <= ARB_IDLE;
         grant_q <= '0;
         last_q  <= CH_IDX_W'(NUM_CH - 1);   // Channel 0 goes first
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (pick_vld) begin
                  grant_q <= grant_t'(1) << pick;
                  last_q  <= pick;
                  state_q <= ARB_BUSY;
               end
            end
            ARB_BUSY: begin
               // Owner released the bus
               if (!(|(grant_q & cyc_vec))) begin
                  grant_q <= '0;
                  state_q <= ARB_IDLE;
               end
            end
            default: begin
               grant_q <= '0;
               state_q <= ARB_IDLE;
            end
         endcase
      end
   end

   assign grant_o = grant_q;

endmodule

//--- mixer/wb_mixer.sv
// Channel mixer in front of the shared Wishbone master port
// Registers the granted channel's request onto the master bus
// and hands ack, err and read data back to that channel only
`timescale 1ns/1ps

module wb_mixer
   import wb_mix_pkg::*;
(
   input  logic    wb_clk_i,
   input  logic    rst_i,
   input  grant_t  grant_i,
   input  wb_req_t ch_req_i [NUM_CH],
   output wb_rsp_t ch_rsp_o [NUM_CH],
   output wb_req_t bus_req_o,
   input  wb_rsp_t bus_rsp_i
);

   wb_req_t ch_masked [NUM_CH];   // Request gated by its grant bit
   wb_req_t sel_req;
   wb_req_t bus_req_q;

   // Mask every channel with its own grant bit
   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         ch_masked[i] = ch_req_i[i] & {$bits(wb_req_t){grant_i[i]}};
      end
   end

   // OR of the masked requests, zero with no grant
   always_comb begin
      sel_req = '0;
      for (int i = 0; i < NUM_CH; i++) begin
         sel_req = sel_req | ch_masked[i];
      end
   end

   // One cycle behind the grant
   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         bus_req_q <= '0;
      end else begin
         bus_req_q <= sel_req;
      end
   end

   assign bus_req_o = bus_req_q;

   // Response goes straight back, ungranted channels see zero
   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         ch_rsp_o[i] = grant_i[i] ? bus_rsp_i : '0;
      end
   end

endmodule

//--- hdl/wb_mem_target.sv
// Word-addressed on-chip memory with a Wishbone target port
// Answers each strobe once, one cycle later, with ack or with err when
// the address lies outside the memory; writes honour the byte selects
`timescale 1ns/1ps

module wb_mem_target
   import wb_mix_pkg::*;
(
   input  logic    wb_clk_i,
   input  logic    rst_i,
   input  wb_req_t bus_req_i,
   output wb_rsp_t bus_rsp_o
);

   logic [DAT_W-1:0]      mem [MEM_WORDS];
   logic [WORD_IDX_W-1:0] word_idx;
   logic                  in_range;
   logic                  strobe;
   logic                  req_hit;   // Strobe not yet answered
   logic                  pend_q;
   logic                  ack_q;
   logic                  err_q;
   logic [DAT_W-1:0]      rd_dat_q;

   assign word_idx = bus_req_i.adr[ADR_WORD_MSB:ADR_WORD_LSB];
   assign in_range = ~|bus_req_i.adr[ADR_W-1:ADR_WORD_MSB+1];
   assign strobe   = bus_req_i.cyc & bus_req_i.stb;
   assign req_hit  = strobe & ~pend_q;

   always_ff @(posedge wb_clk_i) begin
      if (rst_i) begin
         pend_q <= 1'b0;
         ack_q  <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         ack_q <= req_hit & in_range;
         err_q <= req_hit & ~in_range;
         // Held until the strobe goes away
         if (!strobe) begin
            pend_q <= 1'b0;
         end else if (req_hit) begin
            pend_q <= 1'b1;
         end
      end
   end

   // Array access and read data
   always_ff @(posedge wb_clk_i) begin
      if (req_hit && !rst_i) begin
         if (in_range) begin
            if (bus_req_i.we) begin
               for (int b = 0; b < SEL_W; b++) begin
                  if (bus_req_i.sel[b]) begin
                     mem[word_idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8];
                  end
               end
            end
            rd_dat_q <= mem[word_idx];   // Old contents on a write
         end else begin
            rd_dat_q <= '0;   // Nothing to read out of range
         end
      end
   end

   assign bus_rsp_o.ack = ack_q;
   assign bus_rsp_o.err = err_q;
   assign bus_rsp_o.dat = rd_dat_q;

endmodule

//--- hdl/wb_mix_top.sv
// Top level of the shared-bus interconnect
// Five channels reach one memory target through the arbiter and mixer
// On an idle bus ack comes back three edges after cyc and stb rise
`timescale 1ns/1ps

module wb_mix_top
   import wb_mix_pkg::*;
(
   input  logic    wb_clk_i,
   input  logic    rst_i,
   input  wb_req_t ch_req_i [NUM_CH],
   output wb_rsp_t ch_rsp_o [NUM_CH]
);

   grant_t  grant;     // Arbiter to mixer
   wb_req_t bus_req;   // Master side request
   wb_rsp_t bus_rsp;

   wb_arbiter u_arbiter (
      .wb_clk_i (wb_clk_i),
      .rst_i    (rst_i),
      .ch_req_i (ch_req_i),
      .grant_o  (grant)
   );

   wb_mixer u_mixer (
      .wb_clk_i  (wb_clk_i),
      .rst_i     (rst_i),
      .grant_i   (grant),
      .ch_req_i  (ch_req_i),
      .ch_rsp_o  (ch_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   // Single target on the shared bus
   wb_mem_target u_mem (
      .wb_clk_i  (wb_clk_i),
      .rst_i     (rst_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp)
   );

endmodule

//--- verification/wb_mix_properties.sv
// Concurrent checks on the mixer's grant input and response routing
// Bound into every wb_mixer instance, fail_cnt counts assertion failures
`timescale 1ns/1ps

module wb_mix_properties
   import wb_mix_pkg::*;
(
   input logic    wb_clk_i,
   input logic    rst_i,
   input grant_t  grant_i,
   input wb_req_t ch_req_i [NUM_CH],
   input wb_rsp_t ch_rsp_i [NUM_CH],
   input wb_req_t bus_req_i
);

   int                fail_cnt = 0;
   logic [NUM_CH-1:0] cyc_vec;
   logic [NUM_CH-1:0] rsp_vec;   // Ack or err per channel

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         cyc_vec[i] = ch_req_i[i].cyc;
         rsp_vec[i] = ch_rsp_i[i].ack | ch_rsp_i[i].err;
      end
   end

   a_grant_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      $onehot0(grant_i))
      else begin
         fail_cnt++;
         $error("grant is neither one-hot nor zero");
      end

   // Owner keeps the bus while its cyc is up
   a_grant_hold: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      (|(grant_i & cyc_vec)) |=> $stable(grant_i))
      else begin
         fail_cnt++;
         $error("grant moved while the owner held cyc");
      end

   a_rsp_single: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      $onehot0(rsp_vec))
      else begin
         fail_cnt++;
         $error("ack or err seen on more than one channel");
      end

   a_stb_cyc: assert property (@(posedge wb_clk_i) disable iff (rst_i)
      bus_req_i.stb |-> bus_req_i.cyc)
      else begin
         fail_cnt++;
         $error("master stb without cyc");
      end

endmodule

bind wb_mixer wb_mix_properties u_props (
   .wb_clk_i  (wb_clk_i),
   .rst_i     (rst_i),
   .grant_i   (grant_i),
   .ch_req_i  (ch_req_i),
   .ch_rsp_i  (ch_rsp_o),
   .bus_req_i (bus_req_o)
);

//--- verification/wb_mix_tb.sv
// Table-driven testbench for the five-channel Wishbone interconnect
// Directed accesses cover data, byte lanes, range errors and idle latency,
// then all channels contend for the bus with random addresses and data
`timescale 1ns/1ps

module wb_mix_tb
   import wb_mix_pkg::*;
();

   localparam int DRV_DLY     = 10;   // After the rising edge
   localparam int MON_DLY     = 2;
   localparam int IDLE_LAT    = 3;    // Edges from cyc to ack on a free bus
   localparam int ACK_TIMEOUT = 50;
   localparam int NUM_DIR     = 9;

   typedef struct packed {
      logic [CH_IDX_W-1:0] ch;
      logic                we;
      logic [SEL_W-1:0]    sel;
      logic [ADR_W-1:0]    adr;
      logic [DAT_W-1:0]    dat;
      logic                err;   // Expected err
   } stim_t;

   logic             wb_clk;
   logic             rst;
   wb_req_t          ch_req [NUM_CH];
   wb_rsp_t          ch_rsp [NUM_CH];
   logic [DAT_W-1:0] ref_mem [MEM_WORDS];   // Reference memory model
   int               done_q [$];            // Channels in completion order
   int               last_ch;
   int unsigned      seed_val;
   logic [ADR_W-1:0] rnd_adr [NUM_CH];
   stim_t            rnd_stim [NUM_CH];

   stim_t stim_tbl [NUM_DIR] = '{
      '{3'd0, 1'b1, 4'hf, 32'h0000_0010, 32'hdead_beef, 1'b0},
      '{3'd3, 1'b0, 4'hf, 32'h0000_0010, 32'h0000_0000, 1'b0},
      '{3'd1, 1'b1, 4'hf, 32'h0000_0020, 32'h1122_3344, 1'b0},
      '{3'd2, 1'b1, 4'h5, 32'h0000_0020, 32'haabb_ccdd, 1'b0},   // Lanes 0 and 2
      '{3'd4, 1'b0, 4'hf, 32'h0000_0020, 32'h0000_0000, 1'b0},
      '{3'd0, 1'b1, 4'hf, 32'h0000_0004, 32'h5a5a_5a5a, 1'b0},
      '{3'd2, 1'b1, 4'hf, 32'h0000_0404, 32'hffff_ffff, 1'b1},   // Aliases word 1
      '{3'd1, 1'b0, 4'hf, 32'h8000_0004, 32'h0000_0000, 1'b1},
      '{3'd3, 1'b0, 4'hf, 32'h0000_0004, 32'h0000_0000, 1'b0}
   };

   wb_mix_top u_dut (
      .wb_clk_i (wb_clk),
      .rst_i    (rst),
      .ch_req_i (ch_req),
      .ch_rsp_o (ch_rsp)
   );

   initial begin
      wb_clk = 1'b0;
      forever #50 wb_clk = ~wb_clk;
   end

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_rsp(input string name, input wb_rsp_t got, input wb_rsp_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_grant_order(input int got, input int exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: served channel got %0d expected %0d",
                  $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic write_model(input int idx, input logic [SEL_W-1:0] sel,
                              input logic [DAT_W-1:0] dat);
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) begin
            ref_mem[idx][8*b +: 8] = dat[8*b +: 8];
         end
      end
   endtask

   // Starts and ends a posedge plus DRV_DLY
   task automatic run_access(input stim_t s, input bit chk_lat);
      int      ch;
      int      idx;
      int      edges;
      wb_rsp_t got;
      wb_rsp_t exp;
      ch         = int'(s.ch);
      idx        = int'(s.adr[ADR_WORD_MSB:ADR_WORD_LSB]);
      ch_req[ch] = '{cyc: 1'b1, stb: 1'b1, we: s.we, sel: s.sel, adr: s.adr, dat: s.dat};
      edges      = 0;
      got        = '0;
      while (!(got.ack || got.err)) begin
         @(posedge wb_clk);
         #DRV_DLY;
         edges++;
         got = ch_rsp[ch];
         if (!(got.ack || got.err) && edges >= ACK_TIMEOUT) begin
            $display("Channel %0d hung, no ack or err after %0d cycles", ch, edges);
            abort_run();
         end
      end
      ch_req[ch] = '0;
      done_q.push_back(ch);
      exp     = '0;
      exp.ack = ~s.err;
      exp.err = s.err;
      if (!s.err && !s.we) begin
         exp.dat = ref_mem[idx];
      end
      if (s.we) begin
         got.dat = '0;   // Read data carries no meaning on a write
      end
      check_rsp($sformatf("ch_rsp_o[%0d]", ch), got, exp);
      if (chk_lat) begin
         check_count("ack latency", edges, IDLE_LAT);
      end
      if (s.we && !s.err) begin
         write_model(idx, s.sel, s.dat);
      end
   endtask

   // Flags any response on a channel without a request,
   // and stops on the first failed bound assertion
   initial begin
      forever begin
         @(posedge wb_clk);
         #MON_DLY;
         for (int i = 0; i < NUM_CH; i++) begin
            if (ch_rsp[i].ack || ch_rsp[i].err) begin
               if (!ch_req[i].cyc) begin
                  $display("Response on channel %0d which has no request", i);
                  abort_run();
               end
            end
         end
         if (u_dut.u_mixer.u_props.fail_cnt != 0) begin
            $display("A bound assertion on the mixer failed");
            abort_run();
         end
      end
   end

   initial begin
      seed_val = $urandom(32'hb3b0195b);
      rst      = 1'b1;
      for (int i = 0; i < NUM_CH; i++) begin
         ch_req[i] = '0;
      end
      repeat (10) @(posedge wb_clk);
      #DRV_DLY;
      rst = 1'b0;

      // Quiet bus after reset while the monitor watches every channel
      repeat (20) @(posedge wb_clk);
      #DRV_DLY;

      for (int k = 0; k < NUM_DIR; k++) begin
         run_access(stim_tbl[k], 1'b1);
         last_ch = int'(stim_tbl[k].ch);
         @(posedge wb_clk);
         #DRV_DLY;
      end
      done_q.delete();

      // Round 0 writes random words, round 1 reads them back on another channel
      for (int c = 0; c < NUM_CH; c++) begin
         rnd_adr[c] = {22'd0, 8'($urandom), 2'b00};
      end
      for (int r = 0; r < 2; r++) begin
         for (int c = 0; c < NUM_CH; c++) begin
            rnd_stim[c].ch  = CH_IDX_W'(c);
            rnd_stim[c].we  = (r == 0);
            rnd_stim[c].sel = 4'hf;
            rnd_stim[c].adr = (r == 0) ? rnd_adr[c] : rnd_adr[(c + 1) % NUM_CH];
            rnd_stim[c].dat = $urandom;
            rnd_stim[c].err = 1'b0;
         end
         for (int c = 0; c < NUM_CH; c++) begin
            fork
               automatic stim_t s = rnd_stim[c];
               run_access(s, 1'b0);
            join_none
         end
         wait fork;
         for (int k = 0; k < NUM_CH; k++) begin
            check_grant_order(done_q.pop_front(), (last_ch + 1 + k) % NUM_CH);
         end
         @(posedge wb_clk);
         #DRV_DLY;
      end

      if (u_dut.u_mixer.u_props.fail_cnt == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("Bound assertions failed %0d times", u_dut.u_mixer.u_props.fail_cnt);
         $display("tests failed");
         $fatal(1, "Assertion failures during the run");
      end
   end

endmodule

//--- all.f
common/wb_mix_pkg.sv
hdl/wb_arbiter.sv
mixer/wb_mixer.sv
hdl/wb_mem_target.sv
hdl/wb_mix_top.sv
verification/wb_mix_properties.sv
verification/wb_mix_tb.sv

//--- Bender.yml
package:
  name: wb_mix

sources:
  - files:
      - common/wb_mix_pkg.sv
      - hdl/wb_arbiter.sv
      - mixer/wb_mixer.sv
      - hdl/wb_mem_target.sv
      - hdl/wb_mix_top.sv
  - target: test
    files:
      - verification/wb_mix_properties.sv
      - verification/wb_mix_tb.sv
